// ==== capture/capture_ctrl.sv ====
`default_nettype none

module capture_ctrl
    import dbg_pkg::*;
(
    input  wire                   txclk,
    input  wire                   rstn,
    input  wire                   trigger,    // only the rising edge matters
    input  wire [PORT_WIDTH-1:0]  testport,
    output logic                  wr_en,
    output logic [ADDR_W-1:0]     wr_addr,
    output logic [PORT_WIDTH-1:0] wr_data,
    output logic                  trigdone
);

    cap_state_t        state;
    logic              trig_d;
    logic              trig_rise;
    logic [ADDR_W-1:0] fill_cnt;

    assign trig_rise = trigger && !trig_d;

    // edge detect and fill sequencing
    always_ff @(posedge txclk or negedge rstn) begin
        if (!rstn) begin
            trig_d   <= 1'b0;
            state    <= CAP_IDLE;
            fill_cnt <= '0;
        end else begin
            trig_d <= trigger;
            case (state)
                CAP_IDLE: begin
                    fill_cnt <= '0;
                    if (trig_rise) begin
                        state <= CAP_FILL;
                    end
                end
                CAP_FILL: begin
                    // edges seen here are ignored
                    fill_cnt <= fill_cnt + 1'b1;
                    if (fill_cnt == ADDR_W'(SAMPLE_DEPTH - 1)) begin
                        state <= CAP_IDLE;
                    end
                end
                default: state <= CAP_IDLE;
            endcase
        end
    end

    // write port of the buffer, one cycle behind the fill counter
    always_ff @(posedge txclk or negedge rstn) begin
        if (!rstn) begin
            wr_en    <= 1'b0;
            wr_addr  <= '0;
            trigdone <= 1'b0;
        end else begin
            wr_en    <= (state == CAP_FILL);
            wr_addr  <= fill_cnt;
            // pulse as the last word lands in the RAM
            trigdone <= wr_en && (wr_addr == ADDR_W'(SAMPLE_DEPTH - 1));
        end
    end

    always_ff @(posedge txclk) begin
        wr_data <= testport;  // sample of this edge
    end

    a_trigdone_pulse : assert property (
        @(posedge txclk) disable iff (!rstn)
        trigdone |=> !trigdone
    );

    // only the last buffer word may still be written once idle
    a_no_write_idle : assert property (
        @(posedge txclk) disable iff (!rstn)
        (state == CAP_IDLE) && wr_en |-> (wr_addr == ADDR_W'(SAMPLE_DEPTH - 1))
    );

endmodule

`default_nettype wire

// ==== capture/sample_ram.sv ====
`default_nettype none

module sample_ram
    import dbg_pkg::*;
(
    input  wire                   txclk,
    input  wire                   wr_en,
    input  wire [ADDR_W-1:0]      wr_addr,
    input  wire [PORT_WIDTH-1:0]  wr_data,
    input  wire [ADDR_W-1:0]      rd_addr,
    output logic [PORT_WIDTH-1:0] rd_data
);

    // simple dual port, maps to block RAM
    logic [PORT_WIDTH-1:0] mem [SAMPLE_DEPTH];

    always_ff @(posedge txclk) begin
        if (wr_en) begin
            mem[wr_addr] <= wr_data;
        end
    end

    // registered read, one cycle latency
    always_ff @(posedge txclk) begin
        rd_data <= mem[rd_addr];
    end

endmodule

`default_nettype wire

// ==== common/dbg_pkg.sv ====
`default_nettype none

package dbg_pkg;

    // probe geometry
    localparam int PORT_WIDTH   = 32;                    // test port and buffer word width
    localparam int SAMPLE_DEPTH = 1024;                  // samples taken per capture
    localparam int ADDR_W       = $clog2(SAMPLE_DEPTH);  // buffer address width
    localparam int CNT_W        = 10;                    // read count width, 1..1023 words

    // capture controller states
    typedef enum logic {
        CAP_IDLE,   // waiting for a trigger edge
        CAP_FILL    // writing the sample buffer
    } cap_state_t;

    // readout sequencer states
    typedef enum logic [1:0] {
        RD_IDLE,    // no burst in progress
        RD_PREP,    // first address on the RAM
        RD_STREAM   // remaining addresses of the burst
    } rd_state_t;

endpackage

`default_nettype wire

// ==== list.f ====
common/dbg_pkg.sv
src/cmd_latch.sv
capture/capture_ctrl.sv
capture/sample_ram.sv
src/readout_seq.sv
src/debug_probe_top.sv
test/tb_debug_probe.sv

// ==== run.sh ====
#!/bin/sh
# build and run the debug probe testbench with Verilator
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert --top-module tb_debug_probe \
    -f list.f --Mdir obj_dir -o tb_debug_probe
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/tb_debug_probe > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

# the log decides pass or fail
if grep -qx "Test passed" sim.log; then
    exit 0
fi
exit 1

// ==== src/cmd_latch.sv ====
`default_nettype none

module cmd_latch
    import dbg_pkg::*;
(
    input  wire              txclk,
    input  wire              rstn,
    input  wire              porten,      // host command strobe
    input  wire [ADDR_W-1:0] addr,
    input  wire [CNT_W-1:0]  rdnum,
    input  wire              busy,        // from readout_seq
    output logic             start,
    output logic [ADDR_W-1:0] start_addr,
    output logic [CNT_W-1:0]  burst_len
);

    logic accept;

    // commands arriving during a burst or asking for zero words are dropped
    assign accept = porten && !busy && (rdnum != '0);

    always_ff @(posedge txclk or negedge rstn) begin
        if (!rstn) begin
            start <= 1'b0;
        end else begin
            start <= accept;  // one cycle pulse
        end
    end

    // window of the buffer to be read
    always_ff @(posedge txclk) begin
        if (accept) begin
            start_addr <= addr;
            burst_len  <= rdnum;
        end
    end

    // sequencer must hold off new commands once a burst is launched
    a_start_not_busy : assert property (
        @(posedge txclk) disable iff (!rstn)
        start |=> busy
    );

endmodule

`default_nettype wire

// ==== src/debug_probe_top.sv ====
`default_nettype none

module debug_probe_top
    import dbg_pkg::*;
(
    input  wire                  txclk,
    input  wire                  rstn,
    input  wire [PORT_WIDTH-1:0] testport,
    input  wire                  trigger,
    input  wire                  porten,
    input  wire [ADDR_W-1:0]     addr,
    input  wire [CNT_W-1:0]      rdnum,
    input  wire                  tx_sel,
    output wire                  trigdone,
    output wire                  tx_datavalid,
    output wire                  tx_datalast,
    output wire [31:0]           tx_portdata
);

    logic                  start;
    logic [ADDR_W-1:0]     start_addr;
    logic [CNT_W-1:0]      burst_len;
    logic                  busy;
    logic                  wr_en;
    logic [ADDR_W-1:0]     wr_addr;
    logic [PORT_WIDTH-1:0] wr_data;
    logic [ADDR_W-1:0]     rd_addr;
    logic [PORT_WIDTH-1:0] rd_data;

    // host command input
    cmd_latch i_cmd_latch (
        .txclk      (txclk),
        .rstn       (rstn),
        .porten     (porten),
        .addr       (addr),
        .rdnum      (rdnum),
        .busy       (busy),
        .start      (start),
        .start_addr (start_addr),
        .burst_len  (burst_len)
    );

    capture_ctrl i_capture_ctrl (
        .txclk    (txclk),
        .rstn     (rstn),
        .trigger  (trigger),
        .testport (testport),
        .wr_en    (wr_en),
        .wr_addr  (wr_addr),
        .wr_data  (wr_data),
        .trigdone (trigdone)
    );

    sample_ram i_sample_ram (
        .txclk   (txclk),
        .wr_en   (wr_en),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rd_addr (rd_addr),
        .rd_data (rd_data)
    );

    // burst output
    readout_seq i_readout_seq (
        .txclk        (txclk),
        .rstn         (rstn),
        .start        (start),
        .start_addr   (start_addr),
        .burst_len    (burst_len),
        .rd_data      (rd_data),
        .tx_sel       (tx_sel),
        .rd_addr      (rd_addr),
        .busy         (busy),
        .tx_datavalid (tx_datavalid),
        .tx_datalast  (tx_datalast),
        .tx_portdata  (tx_portdata)
    );

endmodule

`default_nettype wire

// ==== src/readout_seq.sv ====
`default_nettype none

module readout_seq
    import dbg_pkg::*;
(
    input  wire                  txclk,
    input  wire                  rstn,
    input  wire                  start,
    input  wire [ADDR_W-1:0]     start_addr,
    input  wire [CNT_W-1:0]      burst_len,
    input  wire [PORT_WIDTH-1:0] rd_data,
    input  wire                  tx_sel,      // output data enable
    output logic [ADDR_W-1:0]    rd_addr,
    output logic                 busy,
    output logic                 tx_datavalid,
    output logic                 tx_datalast,
    output logic [31:0]          tx_portdata
);

    rd_state_t        state;
    logic [CNT_W-1:0] cnt;        // words issued so far
    logic             issue;
    logic             at_last;
    logic             rd_vld;     // read in flight inside the RAM
    logic             rd_last;
    logic [31:0]      tx_q;

    assign issue   = (state != RD_IDLE);  // one read per cycle while active
    assign at_last = (cnt == burst_len - 1'b1);

    // covers the pipeline drain as well
    assign busy = start || issue || rd_vld || tx_datavalid;

    always_ff @(posedge txclk or negedge rstn) begin
        if (!rstn) begin
            state   <= RD_IDLE;
            rd_addr <= '0;
            cnt     <= '0;
        end else begin
            case (state)
                RD_IDLE: begin
                    if (start) begin
                        state   <= RD_PREP;
                        rd_addr <= start_addr;  // first word read in RD_PREP
                        cnt     <= '0;
                    end
                end
                RD_PREP, RD_STREAM: begin
                    rd_addr <= rd_addr + 1'b1;  // wraps at the buffer end
                    cnt     <= cnt + 1'b1;
                    state   <= at_last ? RD_IDLE : RD_STREAM;
                end
                default: state <= RD_IDLE;
            endcase
        end
    end

    // flags follow the read data through the RAM register
    always_ff @(posedge txclk or negedge rstn) begin
        if (!rstn) begin
            rd_vld       <= 1'b0;
            rd_last      <= 1'b0;
            tx_datavalid <= 1'b0;
            tx_datalast  <= 1'b0;
        end else begin
            rd_vld       <= issue;
            rd_last      <= issue && at_last;
            tx_datavalid <= rd_vld;
            tx_datalast  <= rd_last;
        end
    end

    // zero outside a burst
    always_ff @(posedge txclk or negedge rstn) begin
        if (!rstn) begin
            tx_q <= '0;
        end else begin
            tx_q <= rd_vld ? rd_data : '0;
        end
    end

    assign tx_portdata = tx_sel ? tx_q : '0;

    // the burst closes right after its last word
    a_last_in_burst : assert property (
        @(posedge txclk) disable iff (!rstn)
        tx_datalast |=> !tx_datavalid
    );

endmodule

`default_nettype wire

// ==== test/tb_debug_probe.sv ====
`default_nettype none

module tb_debug_probe
    import dbg_pkg::*;
();

    timeunit 1ns;
    timeprecision 1ps;

    logic                  txclk = 1'b0;
    logic                  rstn;
    logic [PORT_WIDTH-1:0] testport;
    logic                  trigger;
    logic                  porten;
    logic [ADDR_W-1:0]     addr;
    logic [CNT_W-1:0]      rdnum;
    logic                  tx_sel;
    wire                   trigdone;
    wire                   tx_datavalid;
    wire                   tx_datalast;
    wire  [31:0]           tx_portdata;

    string test_name = "reset";
    int    errors = 0;
    int    bursts_sent = 0;  // commands that should be accepted
    int    lasts_seen = 0;
    int    dones_seen = 0;

    // reference model state
    logic [PORT_WIDTH-1:0] model_mem [SAMPLE_DEPTH];
    int                    cyc;        // posedges since reset
    logic                  trig_prev;
    logic                  cap_on;
    logic                  done_next;
    int                    cap_k;
    logic                  rd_on;
    int                    rd_p;       // edge that accepted the command
    int                    rd_n;
    logic [ADDR_W-1:0]     rd_a;
    logic                  exp_trigdone;
    logic                  exp_valid;
    logic                  exp_last;
    logic [31:0]           exp_word;   // before tx_sel gating

    debug_probe_top i_dut (
        .txclk        (txclk),
        .rstn         (rstn),
        .testport     (testport),
        .trigger      (trigger),
        .porten       (porten),
        .addr         (addr),
        .rdnum        (rdnum),
        .tx_sel       (tx_sel),
        .trigdone     (trigdone),
        .tx_datavalid (tx_datavalid),
        .tx_datalast  (tx_datalast),
        .tx_portdata  (tx_portdata)
    );

    always #5 txclk = ~txclk;

    // expected outputs for the cycle after each edge
    always @(posedge txclk or negedge rstn) begin : ref_model
        int i;
        if (!rstn) begin
            cyc          = 0;
            trig_prev    = 1'b0;
            cap_on       = 1'b0;
            done_next    = 1'b0;
            cap_k        = 0;
            rd_on        = 1'b0;
            exp_trigdone <= 1'b0;
            exp_valid    <= 1'b0;
            exp_last     <= 1'b0;
            exp_word     <= '0;
        end else begin
            cyc = cyc + 1;
            exp_trigdone <= 1'b0;
            exp_valid    <= 1'b0;
            exp_last     <= 1'b0;
            exp_word     <= '0;
            if (done_next) begin
                exp_trigdone <= 1'b1;  // after edge E+SAMPLE_DEPTH+1
                done_next = 1'b0;
            end
            // samples at E+1 .. E+SAMPLE_DEPTH, edges in between ignored
            if (cap_on) begin
                cap_k = cap_k + 1;
                model_mem[ADDR_W'(cap_k - 1)] = testport;
                if (cap_k == SAMPLE_DEPTH) begin
                    cap_on    = 1'b0;
                    done_next = 1'b1;
                end
            end else if (trigger && !trig_prev) begin
                cap_on = 1'b1;
                cap_k  = 0;
            end
            trig_prev = trigger;
            // busy from P+1 through P+3+n
            if (porten && !rd_on && rdnum != '0) begin
                rd_on = 1'b1;
                rd_p  = cyc;
                rd_n  = int'(rdnum);
                rd_a  = addr;
            end
            if (rd_on) begin
                i = cyc - rd_p - 3;
                if (i >= 0 && i < rd_n) begin
                    exp_valid <= 1'b1;
                    exp_last  <= (i == rd_n - 1);
                    exp_word  <= model_mem[ADDR_W'((int'(rd_a) + i) % SAMPLE_DEPTH)];
                end else if (i >= rd_n) begin
                    rd_on = 1'b0;
                end
            end
        end
    end

    a_trigdone : assert property (@(posedge txclk) disable iff (!rstn)
        trigdone == exp_trigdone)
        else report_mismatch("trigdone", 32'($sampled(exp_trigdone)), 32'($sampled(trigdone)));

    a_valid : assert property (@(posedge txclk) disable iff (!rstn)
        tx_datavalid == exp_valid)
        else report_mismatch("tx_datavalid", 32'($sampled(exp_valid)),
                             32'($sampled(tx_datavalid)));

    a_last : assert property (@(posedge txclk) disable iff (!rstn)
        tx_datalast == exp_last)
        else report_mismatch("tx_datalast", 32'($sampled(exp_last)),
                             32'($sampled(tx_datalast)));

    // zero whenever tx_sel is low or no word is out
    a_data : assert property (@(posedge txclk) disable iff (!rstn)
        tx_portdata == (tx_sel ? exp_word : 32'h0))
        else report_mismatch("tx_portdata", $sampled(tx_sel) ? $sampled(exp_word) : 32'h0,
                             $sampled(tx_portdata));

    always @(negedge txclk) begin
        if (rstn && trigdone) dones_seen++;
        if (rstn && tx_datalast) lasts_seen++;
    end

    task automatic report_mismatch(input string what, input logic [31:0] expv,
                                   input logic [31:0] actv);
        errors++;
        $display("error %s: %s expected %0h, actual %0h", test_name, what, expv, actv);
    endtask

    task automatic step();
        @(negedge txclk);
        testport = $urandom();
    endtask

    task automatic issue_cmd(input int a, input int n);
        step();
        porten = 1'b1;
        addr   = ADDR_W'(a);
        rdnum  = CNT_W'(n);
        step();
        porten = 1'b0;
    endtask

    task automatic wait_burst_end(input int n);
        int waited;
        waited = 0;
        while (!tx_datalast && waited < n + 8) begin
            step();
            waited++;
        end
        if (!tx_datalast) begin
            errors++;
            $display("%s: tx_datalast did not come within %0d cycles", test_name, n + 8);
        end
        step();
        step();
    endtask

    task automatic read_burst(input string name, input int a, input int n);
        test_name = name;
        issue_cmd(a, n);
        bursts_sent++;
        wait_burst_end(n);
    endtask

    task automatic run_capture(input string name, input logic extra_edge);
        int waited;
        test_name = name;
        step();
        trigger = 1'b1;
        step();
        step();
        trigger = 1'b0;
        if (extra_edge) begin
            repeat (300) step();
            trigger = 1'b1;  // lands inside the fill
            step();
            trigger = 1'b0;
        end
        waited = 0;
        while (!trigdone && waited < SAMPLE_DEPTH + 16) begin
            step();
            waited++;
        end
        if (!trigdone) begin
            errors++;
            $display("%s: trigdone never came after the trigger edge", test_name);
        end
        step();
        step();
    endtask

    task automatic watchdog(input int cycles);
        #(cycles * 10);
        $display("timeout: run did not finish within %0d cycles", cycles);
        $display("Test failed");
        $finish;
    endtask

    initial begin
        int rnd_addr [8];
        int rnd_len [5];
        int limit;
        int k;
        rstn     = 1'b0;
        testport = '0;
        trigger  = 1'b0;
        porten   = 1'b0;
        addr     = '0;
        rdnum    = '0;
        tx_sel   = 1'b1;
        void'($urandom(32'he08d_b1d5));
        for (k = 0; k < 8; k++) begin
            rnd_addr[k] = int'($urandom % SAMPLE_DEPTH);
        end
        limit = 2 * SAMPLE_DEPTH + 1 + 1023 + 40 + 64 + 200;
        for (k = 0; k < 5; k++) begin
            rnd_len[k] = 1 + int'($urandom % 256);
            limit      = limit + rnd_len[k];
        end
        fork
            watchdog(limit);
        join_none

        repeat (2) step();
        rstn = 1'b1;
        repeat (4) step();

        run_capture("capture_retrigger", 1'b1);
        read_burst("burst_one", rnd_addr[0], 1);
        read_burst("burst_full", rnd_addr[1], 1023);
        read_burst("burst_wrap", 1000, 40);  // crosses the buffer end
        for (k = 0; k < 3; k++) begin
            read_burst("burst_random", rnd_addr[k + 2], rnd_len[k]);
        end
        tx_sel = 1'b0;
        read_burst("tx_sel_low", rnd_addr[5], rnd_len[3]);
        tx_sel = 1'b1;

        // second command in the middle of a running burst
        test_name = "busy_drop";
        issue_cmd(rnd_addr[6], 64);
        bursts_sent++;
        repeat (20) step();
        porten = 1'b1;
        addr   = ADDR_W'(rnd_addr[7]);
        rdnum  = CNT_W'(30);
        step();
        porten = 1'b0;
        wait_burst_end(64);
        test_name = "rdnum_zero";
        issue_cmd(rnd_addr[7], 0);
        repeat (8) step();

        run_capture("capture_second", 1'b0);
        read_burst("after_second_capture", rnd_addr[7], rnd_len[4]);

        test_name = "summary";
        if (dones_seen != 2) report_mismatch("trigdone pulses", 2, dones_seen);
        if (lasts_seen != bursts_sent) report_mismatch("bursts", bursts_sent, lasts_seen);
        $display("summary: %0d errors, %0d bursts, %0d captures", errors, lasts_seen,
                 dones_seen);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
